/* verilog.f */
hdl/store_buffer_pkg.sv
hdl/store_xfer_if.sv
hdl/spec_queue.sv
hdl/commit_queue.sv
hdl/store_buffer.sv
verification/store_buffer_props.sv
verification/tb_store_buffer.sv

/* verification/tb_store_buffer.sv */
// random-stimulus testbench for the store buffer that runs as the simulation top and checks it against a queue model
module tb_store_buffer
    import store_buffer_pkg::*;
();

    localparam int CLK_HALF = 10;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 8;
    localparam int STIM_CYCLES = 2000;
    // draining a full buffer needs only a few cycles per entry, so twice the run is ample
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;
    localparam int OFF_HI = PAGE_OFFSET_W - 1;
    localparam int OFF_LO = WORD_OFFSET_LSB;

    // one buffered store as the model keeps it
    typedef struct packed {
        store_addr_t       addr;
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0]   be;
        logic [SIZE_W-1:0] size;
    } entry_t;

    logic clk_i = 1'b0;
    logic rst_ni, flush_i, valid_i, valid_without_flush_i, commit_i, data_gnt_i;
    store_addr_t paddr_i;
    logic [DATA_W-1:0] data_i;
    logic [BE_W-1:0] be_i;
    logic [SIZE_W-1:0] data_size_i;
    logic [PAGE_OFFSET_W-1:0] page_offset_i;
    logic ready_o, commit_ready_o, no_st_pending_o, store_buffer_empty_o;
    logic page_offset_matches_o, data_req_o;
    logic [DCACHE_INDEX_W-1:0] address_index_o;
    logic [DCACHE_TAG_W-1:0] address_tag_o;
    logic [DATA_W-1:0] data_wdata_o;
    logic [BE_W-1:0] data_be_o;
    logic [SIZE_W-1:0] data_size_o;

    // the model keeps the oldest entry at index 0 of each queue
    entry_t spec_q[$];
    entry_t commit_q[$];
    logic [31:0] rng_state = 32'd29;
    int unsigned cycle_cnt = 0;
    int unsigned writes_seen = 0;

    store_buffer DUT (.*);

    always #CLK_HALF clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout: the run did not end within %0d cycles",
                TIMEOUT_CYCLES));
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                $time, name, got, exp));
        end
    endtask

    // the cache port shows the tag above the index so together they form the raw address
    task automatic check_write(input store_addr_t exp_addr, input logic [DATA_W-1:0] exp_data,
                               input logic [BE_W-1:0] exp_be, input logic [SIZE_W-1:0] exp_size);
        logic [ADDR_W-1:0] raw;
        raw = exp_addr;
        if ({address_tag_o, address_index_o} !== raw || data_wdata_o !== exp_data
                || data_be_o !== exp_be || data_size_o !== exp_size) begin
            stop_with_failure($sformatf(
                "CHECK FAILED at time %0t: cache write %h %h %h %0d, expected %h %h %h %0d",
                $time, {address_tag_o, address_index_o},
                data_wdata_o, data_be_o, data_size_o, raw, exp_data, exp_be, exp_size));
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus and reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // a load hits when bits 11 to 3 equal those of any buffered or presented store
    function automatic logic model_match();
        logic hit;
        logic [ADDR_W-1:0] raw;
        raw = paddr_i;
        hit = valid_without_flush_i && (raw[OFF_HI:OFF_LO] == page_offset_i[OFF_HI:OFF_LO]);
        foreach (spec_q[i]) begin
            raw = spec_q[i].addr;
            hit |= (raw[OFF_HI:OFF_LO] == page_offset_i[OFF_HI:OFF_LO]);
        end
        foreach (commit_q[i]) begin
            raw = commit_q[i].addr;
            hit |= (raw[OFF_HI:OFF_LO] == page_offset_i[OFF_HI:OFF_LO]);
        end
        return hit;
    endfunction

    task automatic check_outputs();
        check_flag("ready_o", ready_o, (spec_q.size() < DEPTH_SPEC - 1) || commit_i);
        check_flag("commit_ready_o", commit_ready_o, commit_q.size() < DEPTH_COMMIT);
        check_flag("no_st_pending_o", no_st_pending_o, commit_q.size() == 0);
        check_flag("store_buffer_empty_o", store_buffer_empty_o,
            (spec_q.size() == 0) && (commit_q.size() == 0));
        check_flag("page_offset_matches_o", page_offset_matches_o, model_match());
        check_flag("data_req_o", data_req_o, commit_q.size() != 0);
        // the model head only moves on a grant, so a waiting request is compared every cycle
        if (commit_q.size() != 0) begin
            check_write(commit_q[0].addr, commit_q[0].data, commit_q[0].be, commit_q[0].size);
        end
    endtask

    // applies what the coming rising edge does to the buffer
    task automatic update_model();
        logic req;
        req = commit_q.size() != 0;
        if (req && data_gnt_i) begin
            commit_q.delete(0);
            writes_seen++;
        end
        if (flush_i) begin
            spec_q.delete();
        end else begin
            if (commit_i) begin
                commit_q.push_back(spec_q.pop_front());
            end
            if (valid_i) begin
                spec_q.push_back('{paddr_i, data_i, be_i, data_size_i});
            end
        end
    endtask

    task automatic run_cycle(input logic draining);
        logic [31:0] r;
        logic [ADDR_W-1:0] addr;
        logic can_commit;
        logic has_room;
        @(posedge clk_i);
        #DRIVE_DELAY;
        can_commit = (spec_q.size() != 0) && (commit_q.size() < DEPTH_COMMIT);
        has_room = spec_q.size() < DEPTH_SPEC - 1;
        r = next_random();
        valid_i = 1'b0;
        commit_i = 1'b0;
        flush_i = 1'b0;
        if (draining) begin
            commit_i = can_commit;
        end else if (r[3:0] < 4'd6) begin
            valid_i = has_room;
        end else if (r[3:0] < 4'd10) begin
            commit_i = can_commit;
        end else if (r[3:0] < 4'd13) begin
            // a commit in the same cycle frees the reserved slot for the push
            commit_i = can_commit;
            valid_i = can_commit || has_room;
        end else if (r[3:0] == 4'd13) begin
            flush_i = 1'b1;
        end
        data_gnt_i = draining || r[4];
        valid_without_flush_i = r[5];
        be_i = r[15:8];
        data_size_i = r[17:16];
        addr = next_random();
        // only a few distinct double words are used so that loads hit often
        addr[OFF_HI:OFF_LO+2] = '0;
        paddr_i = addr;
        r = next_random();
        page_offset_i = r[PAGE_OFFSET_W-1:0];
        if (!r[31]) begin
            page_offset_i[OFF_HI:OFF_LO+2] = '0;
        end
        data_i = {next_random(), next_random()};
        @(negedge clk_i);
        check_outputs();
        update_model();
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_ni = 1'b0;
        flush_i = 1'b0;
        valid_i = 1'b0;
        valid_without_flush_i = 1'b0;
        commit_i = 1'b0;
        data_gnt_i = 1'b0;
        paddr_i = '0;
        data_i = '0;
        be_i = '0;
        data_size_i = '0;
        page_offset_i = '0;
        repeat (RESET_CYCLES - 1) @(posedge clk_i);
        @(negedge clk_i);
        check_outputs();
        @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_outputs();
        repeat (STIM_CYCLES) run_cycle(1'b0);
        // stop pushing, commit what is left and wait until the buffer reports empty
        do begin
            run_cycle(1'b1);
        end while (!store_buffer_empty_o);
        if (writes_seen == 0) begin
            stop_with_failure("no store reached the data cache port during the run");
        end else begin
            $display("%0d stores written through the cache port", writes_seen);
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* verification/store_buffer_props.sv */
// assertions on the usage rules and occupancy bounds of a store queue that are bound into both queues
module store_buffer_props #(
    parameter int DEPTH = 4,
    parameter bit HAS_FLUSH = 1'b1
) (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   flush_i,
    input logic                   push_i,
    input logic                   push_ok_i,
    input logic                   pop_i,
    input logic                   empty_i,
    input logic [$clog2(DEPTH):0] count_i
);

    // a flush and a pop of the head are never requested together
    if (HAS_FLUSH) begin : g_flush
        a_no_pop_with_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
            !(pop_i && flush_i)) else $error("pop and flush requested in the same cycle");
    end

    // the writer only pushes while the queue reports room
    a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> push_ok_i) else $error("push into a full queue");

    a_no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_i) else $error("pop from an empty queue");

    a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_i <= DEPTH) else $error("entry count above the queue depth");

endmodule

// on the speculative side pushes come from the core and pops are commits
bind spec_queue store_buffer_props #(.DEPTH(store_buffer_pkg::DEPTH_SPEC)) u_spec_props (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .push_i    (valid_i),
    .push_ok_i (ready_o),
    .pop_i     (commit_i),
    .empty_i   (spec_empty_o),
    .count_i   (spec_cnt_q)
);

// the commit queue has no flush, its pushes are transfers and its pops are granted cache writes
bind commit_queue store_buffer_props #(
    .DEPTH(store_buffer_pkg::DEPTH_COMMIT),
    .HAS_FLUSH(1'b0)
) u_commit_props (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (1'b0),
    .push_i    (xfer.commit),
    .push_ok_i (commit_ready_o),
    .pop_i     (data_req_o && data_gnt_i),
    .empty_i   (no_st_pending_o),
    .count_i   (commit_cnt_q)
);

/* hdl/store_buffer.sv */
// store buffer top level, joins the speculative and the commit queue for the load/store unit
module store_buffer
    import store_buffer_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,

    // core side, all strobes
    input  logic                      valid_i,
    input  logic                      valid_without_flush_i,
    input  logic                      commit_i,
    input  store_addr_t               paddr_i,
    input  logic [DATA_W-1:0]         data_i,
    input  logic [BE_W-1:0]           be_i,
    input  logic [SIZE_W-1:0]         data_size_i,
    output logic                      ready_o,
    output logic                      commit_ready_o,

    // load offset check and drain status
    input  logic [PAGE_OFFSET_W-1:0]  page_offset_i,
    output logic                      page_offset_matches_o,
    output logic                      no_st_pending_o,
    output logic                      store_buffer_empty_o,

    // data cache write port, request held until granted
    input  logic                      data_gnt_i,
    output logic                      data_req_o,
    output logic [DCACHE_INDEX_W-1:0] address_index_o,
    output logic [DCACHE_TAG_W-1:0]   address_tag_o,
    output logic [DATA_W-1:0]         data_wdata_o,
    output logic [BE_W-1:0]           data_be_o,
    output logic [SIZE_W-1:0]         data_size_o
);

    // ----------------------------------------------------------------------
    // queue interconnect
    // ----------------------------------------------------------------------
    store_xfer_if xfer_if ();
    logic spec_empty;

    spec_queue u_spec (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .valid_without_flush_i (valid_without_flush_i),
        .commit_i              (commit_i),
        .paddr_i               (paddr_i),
        .data_i                (data_i),
        .be_i                  (be_i),
        .data_size_i           (data_size_i),
        .page_offset_i         (page_offset_i),
        .ready_o               (ready_o),
        .spec_empty_o          (spec_empty),
        .xfer                  (xfer_if.source)
    );

    // the commit queue also owns the cache port and the merged status
    commit_queue u_commit (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .page_offset_i         (page_offset_i),
        .spec_empty_i          (spec_empty),
        .data_gnt_i            (data_gnt_i),
        .commit_ready_o        (commit_ready_o),
        .no_st_pending_o       (no_st_pending_o),
        .store_buffer_empty_o  (store_buffer_empty_o),
        .page_offset_matches_o (page_offset_matches_o),
        .data_req_o            (data_req_o),
        .address_index_o       (address_index_o),
        .address_tag_o         (address_tag_o),
        .data_wdata_o          (data_wdata_o),
        .data_be_o             (data_be_o),
        .data_size_o           (data_size_o),
        .xfer                  (xfer_if.sink)
    );

endmodule

/* hdl/commit_queue.sv */
// non-speculative store queue, drains committed stores in order to the data cache write port
module commit_queue
    import store_buffer_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [PAGE_OFFSET_W-1:0]  page_offset_i,
    input  logic                      spec_empty_i,
    input  logic                      data_gnt_i,
    output logic                      commit_ready_o,
    output logic                      no_st_pending_o,
    output logic                      store_buffer_empty_o,
    output logic                      page_offset_matches_o,
    output logic                      data_req_o,
    output logic [DCACHE_INDEX_W-1:0] address_index_o,
    output logic [DCACHE_TAG_W-1:0]   address_tag_o,
    output logic [DATA_W-1:0]         data_wdata_o,
    output logic [BE_W-1:0]           data_be_o,
    output logic [SIZE_W-1:0]         data_size_o,
    store_xfer_if.sink                xfer
);

    // payload storage, filled from the speculative head on each commit
    store_addr_t       addr_q [DEPTH_COMMIT];
    logic [DATA_W-1:0] data_q [DEPTH_COMMIT];
    logic [BE_W-1:0]   be_q   [DEPTH_COMMIT];
    logic [SIZE_W-1:0] size_q [DEPTH_COMMIT];

    logic [DEPTH_COMMIT-1:0] valid_q;
    logic [COMMIT_PTR_W-1:0] rd_ptr_q;
    logic [COMMIT_PTR_W-1:0] wr_ptr_q;
    logic [COMMIT_CNT_W-1:0] commit_cnt_q;

    // head accepted by the cache in this cycle
    logic retire;
    // the load offset hits a committed store
    logic commit_match;
    logic [DW_OFFSET_W-1:0] load_dw_offset;

    // ----------------------------------------------------------------------
    // status flags
    // ----------------------------------------------------------------------
    assign commit_ready_o = (commit_cnt_q < COMMIT_CNT_W'(DEPTH_COMMIT));
    // nothing is pending once every committed store reached the cache
    assign no_st_pending_o = (commit_cnt_q == '0);
    assign store_buffer_empty_o = spec_empty_i && no_st_pending_o;

    // ----------------------------------------------------------------------
    // cache write port
    // ----------------------------------------------------------------------
    // the head stays put until granted, so the fields are stable while waiting
    assign data_req_o = valid_q[rd_ptr_q];
    assign retire = data_req_o && data_gnt_i;

    assign address_index_o = addr_q[rd_ptr_q].cache.index;
    assign address_tag_o = addr_q[rd_ptr_q].cache.tag;
    assign data_wdata_o = data_q[rd_ptr_q];
    assign data_be_o = be_q[rd_ptr_q];
    assign data_size_o = size_q[rd_ptr_q];

    // ----------------------------------------------------------------------
    // pointers, valid bits and the entry count
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            commit_cnt_q <= '0;
        end else begin
            // a transfer only arrives while there is room, so no slot is overwritten
            if (xfer.commit) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (retire) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({xfer.commit, retire})
                2'b10: commit_cnt_q <= commit_cnt_q + 1'b1;
                2'b01: commit_cnt_q <= commit_cnt_q - 1'b1;
                default: commit_cnt_q <= commit_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer.commit) begin
            addr_q[wr_ptr_q] <= xfer.addr;
            data_q[wr_ptr_q] <= xfer.data;
            be_q[wr_ptr_q] <= xfer.be;
            size_q[wr_ptr_q] <= xfer.size;
        end
    end

    // ----------------------------------------------------------------------
    // page offset check
    // ----------------------------------------------------------------------
    assign load_dw_offset = page_offset_i[PAGE_OFFSET_W-1:WORD_OFFSET_LSB];

    always_comb begin
        commit_match = 1'b0;
        for (int i = 0; i < DEPTH_COMMIT; i++) begin
            if (valid_q[i] && (addr_q[i].page.dw_offset == load_dw_offset)) begin
                commit_match = 1'b1;
            end
        end
    end

    // a load must wait if any older store, speculative or not, may overlap
    assign page_offset_matches_o = commit_match || xfer.spec_match;

endmodule

/* hdl/spec_queue.sv */
// speculative store queue, accepts stores from the core and hands them to the commit queue on commit
module spec_queue
    import store_buffer_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     valid_i,
    input  logic                     valid_without_flush_i,
    input  logic                     commit_i,
    input  store_addr_t              paddr_i,
    input  logic [DATA_W-1:0]        data_i,
    input  logic [BE_W-1:0]          be_i,
    input  logic [SIZE_W-1:0]        data_size_i,
    input  logic [PAGE_OFFSET_W-1:0] page_offset_i,
    output logic                     ready_o,
    output logic                     spec_empty_o,
    store_xfer_if.source             xfer
);

    // payload storage, written on push and never cleared
    store_addr_t       addr_q [DEPTH_SPEC];
    logic [DATA_W-1:0] data_q [DEPTH_SPEC];
    logic [BE_W-1:0]   be_q   [DEPTH_SPEC];
    logic [SIZE_W-1:0] size_q [DEPTH_SPEC];

    // per-entry valid bits, these take part in the offset check
    logic [DEPTH_SPEC-1:0] valid_q;
    logic [SPEC_PTR_W-1:0] rd_ptr_q;
    logic [SPEC_PTR_W-1:0] wr_ptr_q;
    logic [SPEC_CNT_W-1:0] spec_cnt_q;

    // double-word part of the load's page offset
    logic [DW_OFFSET_W-1:0] load_dw_offset;

    // ----------------------------------------------------------------------
    // core side status
    // ----------------------------------------------------------------------
    // one slot is kept in reserve, a commit in the same cycle frees one again
    assign ready_o = (spec_cnt_q < SPEC_CNT_W'(DEPTH_SPEC - 1)) || commit_i;
    assign spec_empty_o = (spec_cnt_q == '0);

    // ----------------------------------------------------------------------
    // pointers, valid bits and the entry count
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            spec_cnt_q <= '0;
        end else if (flush_i) begin
            // everything still speculative is dropped, a push in this cycle too
            valid_q <= '0;
            wr_ptr_q <= rd_ptr_q;
            spec_cnt_q <= '0;
        end else begin
            if (valid_i) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            // the entry left behind must no longer match loads
            if (commit_i) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({valid_i, commit_i})
                2'b10: spec_cnt_q <= spec_cnt_q + 1'b1;
                2'b01: spec_cnt_q <= spec_cnt_q - 1'b1;
                default: spec_cnt_q <= spec_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            addr_q[wr_ptr_q] <= paddr_i;
            data_q[wr_ptr_q] <= data_i;
            be_q[wr_ptr_q] <= be_i;
            size_q[wr_ptr_q] <= data_size_i;
        end
    end

    // ----------------------------------------------------------------------
    // transfer towards the commit queue
    // ----------------------------------------------------------------------
    // the head is always presented, the strobe says when it is taken
    assign xfer.commit = commit_i;
    assign xfer.addr = addr_q[rd_ptr_q];
    assign xfer.data = data_q[rd_ptr_q];
    assign xfer.be = be_q[rd_ptr_q];
    assign xfer.size = size_q[rd_ptr_q];

    // ----------------------------------------------------------------------
    // page offset check over the speculative side
    // ----------------------------------------------------------------------
    assign load_dw_offset = page_offset_i[PAGE_OFFSET_W-1:WORD_OFFSET_LSB];

    always_comb begin
        // the store on the inputs counts even before it is written
        xfer.spec_match = valid_without_flush_i && (paddr_i.page.dw_offset == load_dw_offset);
        for (int i = 0; i < DEPTH_SPEC; i++) begin
            if (valid_q[i] && (addr_q[i].page.dw_offset == load_dw_offset)) begin
                xfer.spec_match = 1'b1;
            end
        end
    end

endmodule

/* hdl/store_xfer_if.sv */
// hand-over of a committed store and of the speculative offset match from the speculative to the commit queue
interface store_xfer_if
    import store_buffer_pkg::*;
();

    // strobe, the head entry moves to the commit queue at this edge
    logic              commit;
    // head entry of the speculative queue
    store_addr_t       addr;
    logic [DATA_W-1:0] data;
    logic [BE_W-1:0]   be;
    logic [SIZE_W-1:0] size;
    // load offset hits a speculative entry or the store being presented
    logic              spec_match;

    // the speculative queue drives every field
    modport source (
        output commit, addr, data, be, size, spec_match
    );

    // the commit queue captures the entry and merges the match
    modport sink (
        input commit, addr, data, be, size, spec_match
    );

endinterface

/* hdl/store_buffer_pkg.sv */
// shared widths, queue depths and the physical address decode, imported by every store buffer block
package store_buffer_pkg;

    // ----------------------------------------------------------------------
    // datapath widths
    // ----------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int BE_W = 8;
    localparam int SIZE_W = 2;

    // queue depths, both are powers of two so the pointers wrap by themselves
    localparam int DEPTH_SPEC = 4;
    localparam int DEPTH_COMMIT = 4;
    localparam int SPEC_PTR_W = $clog2(DEPTH_SPEC);
    localparam int COMMIT_PTR_W = $clog2(DEPTH_COMMIT);
    // counters need one more bit than the pointers to tell full from empty
    localparam int SPEC_CNT_W = SPEC_PTR_W + 1;
    localparam int COMMIT_CNT_W = COMMIT_PTR_W + 1;

    // ----------------------------------------------------------------------
    // address split for the data cache and for the load/store page check
    // ----------------------------------------------------------------------
    localparam int DCACHE_INDEX_W = 12;
    localparam int DCACHE_TAG_W = 20;
    localparam int PAGE_OFFSET_W = 12;
    // offsets are compared at double-word granularity
    localparam int WORD_OFFSET_LSB = 3;
    localparam int DW_OFFSET_W = PAGE_OFFSET_W - WORD_OFFSET_LSB;

    // one physical address, seen either by the cache or by the page checker
    typedef union packed {
        // the cache port wants the tag above the set index
        struct packed {
            logic [DCACHE_TAG_W-1:0]   tag;
            logic [DCACHE_INDEX_W-1:0] index;
        } cache;
        // the page view isolates the double-word offset used for matching
        struct packed {
            logic [ADDR_W-PAGE_OFFSET_W-1:0] frame;
            logic [DW_OFFSET_W-1:0]          dw_offset;
            logic [WORD_OFFSET_LSB-1:0]      byte_offset;
        } page;
    } store_addr_t;

endpackage
